//--- source/calc_config.svh
// Width and divider timing constants shared by the calculator package, RTL and checker
`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

// Operand and result width in bits
`define CALC_WIDTH 32

// Restoring divider resolves one quotient bit per cycle
// so it needs one iteration per operand bit
`define CALC_DIV_STEPS `CALC_WIDTH

`endif

//--- source/calc_pkg.sv
// Opcode and request/response types shared by every calculator block and the testbench
`include "calc_config.svh"

package calc_pkg;

  // Operation select carried with each request
  // One two-bit code per operation
  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_MUL = 2'b10,
    OP_DIV = 2'b11
  } calc_op_e;

  // Host request
  // a is the left operand and the dividend
  // b is the right operand and the divisor
  typedef struct packed {
    logic [`CALC_WIDTH-1:0] a;
    logic [`CALC_WIDTH-1:0] b;
    calc_op_e               op;
  } calc_req_t;

  // Response returned with ack
  // Multiply keeps the low word only
  // Divide returns the unsigned quotient
  // div_by_zero only ever set for OP_DIV with b of zero
  typedef struct packed {
    logic [`CALC_WIDTH-1:0] result;
    logic                   div_by_zero;
  } calc_rsp_t;

endpackage

//--- source/calc_handshake.sv
// Four-phase req/ack slave that launches one operation per request and holds the answer
`timescale 1ns/1ps
`include "calc_config.svh"

module calc_handshake
  import calc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      req,
  input  calc_req_t req_data,
  output logic      ack,
  output calc_rsp_t rsp,
  output logic      start,
  output calc_req_t op_req,
  input  logic      alu_done,
  input  calc_rsp_t alu_rsp,
  input  logic      div_done,
  input  calc_rsp_t div_rsp
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    ACK,
    RELEASE
  } state_e;

  state_e    state;
  logic      take;
  logic      any_done;
  calc_rsp_t done_rsp;

  // New request only when nothing is in flight
  assign take     = (state == IDLE) && req && !ack;
  assign any_done = alu_done || div_done;
  // Units are one-hot on done so a simple select is enough
  assign done_rsp = alu_done ? alu_rsp : div_rsp;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      start <= 1'b0;
      ack   <= 1'b0;
      rsp   <= '0;
    end else begin
      // Start is a single-cycle pulse
      start <= 1'b0;
      case (state)
        IDLE: begin
          if (take) begin
            start <= 1'b1;
            state <= BUSY;
          end
        end
        BUSY: begin
          // Response registered here and frozen until the next request
          if (any_done) begin
            rsp   <= done_rsp;
            ack   <= 1'b1;
            state <= ACK;
          end
        end
        ACK: begin
          // Hold ack and rsp for as long as the host keeps req high
          if (!req) begin
            ack   <= 1'b0;
            state <= RELEASE;
          end
        end
        RELEASE: begin
          // One turnaround cycle with ack low before a new capture
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request copy seen by both units
  always_ff @(posedge clk) begin
    if (take) begin
      op_req <= req_data;
    end
  end

  // A unit finishing while no operation was launched means a unit misfired
  assert property (@(posedge clk) disable iff (rst) any_done |-> state == BUSY)
    else $error("done pulse outside BUSY state");

  assert property (@(posedge clk) disable iff (rst) !(alu_done && div_done))
    else $error("ALU and divider finished in the same cycle");

  // Host must not change the request under a raised req
  assert property (@(posedge clk) disable iff (rst) (req && $past(req)) |-> $stable(req_data))
    else $error("req_data changed while req was high");

endmodule

//--- source/calc_alu.sv
// Single-cycle add, subtract and low-word multiply unit behind the calculator handshake
`timescale 1ns/1ps
`include "calc_config.svh"

module calc_alu
  import calc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  calc_req_t op_req,
  output logic      done,
  output calc_rsp_t rsp
);

  logic                   accept;
  logic [`CALC_WIDTH-1:0] result;

  // Divide requests belong to the divider
  assign accept = start && (op_req.op != OP_DIV);

  always_comb begin
    case (op_req.op)
      OP_ADD:  result = op_req.a + op_req.b;
      OP_SUB:  result = op_req.a - op_req.b;
      // Same-width operands so the product truncates to the low word
      OP_MUL:  result = op_req.a * op_req.b;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else begin
      done <= accept;
    end
  end

  // Result register only moves on an accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp <= '{result: result, div_by_zero: 1'b0};
    end
  end

  // Handshake relies on a one-cycle done pulse with no new start on top of it
  assert property (@(posedge clk) disable iff (rst) done |-> !accept)
    else $error("ALU done not a single-cycle pulse after its start");

endmodule

//--- source/calc_divider.sv
// Iterative restoring unsigned divider used by the calculator for OP_DIV requests
`timescale 1ns/1ps
`include "calc_config.svh"

module calc_divider
  import calc_pkg::*;
#(
  parameter int WIDTH = `CALC_WIDTH
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  calc_req_t op_req,
  output logic      done,
  output calc_rsp_t rsp
);

  localparam int STEPS = `CALC_DIV_STEPS;
  localparam int CW    = $clog2(STEPS + 1);

  logic             accept;
  logic             div_zero;
  logic             busy;
  logic [CW-1:0]    count;
  logic             last_step;
  // Partial remainder, dividend shifting into quotient, and held divisor
  logic [WIDTH-1:0] rem_q;
  logic [WIDTH-1:0] quot_q;
  logic [WIDTH-1:0] dvsr_q;
  logic [WIDTH:0]   partial;
  logic [WIDTH:0]   diff;
  logic             q_bit;
  logic [WIDTH-1:0] rem_next;
  logic [WIDTH-1:0] quot_next;

  assign accept    = start && (op_req.op == OP_DIV);
  assign div_zero  = (op_req.b == '0);
  assign last_step = busy && (count == CW'(1));

  // One restoring step
  // Shift the next dividend bit into the remainder and try the subtract
  always_comb begin
    partial   = {rem_q, quot_q[WIDTH-1]};
    diff      = partial - {1'b0, dvsr_q};
    // Borrow out of the top bit means the subtract went negative
    q_bit     = ~diff[WIDTH];
    rem_next  = q_bit ? diff[WIDTH-1:0] : partial[WIDTH-1:0];
    quot_next = {quot_q[WIDTH-2:0], q_bit};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (accept) begin
        // Zero divisor skips the iterations entirely
        if (div_zero) begin
          done <= 1'b1;
        end else begin
          busy  <= 1'b1;
          count <= CW'(STEPS);
        end
      end else if (busy) begin
        count <= count - CW'(1);
        if (last_step) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    if (accept) begin
      rem_q  <= '0;
      quot_q <= op_req.a;
      dvsr_q <= op_req.b;
      if (div_zero) begin
        rsp <= '{result: '0, div_by_zero: 1'b1};
      end
    end else if (busy) begin
      rem_q  <= rem_next;
      quot_q <= quot_next;
      // Final quotient taken straight from the last step
      if (last_step) begin
        rsp <= '{result: quot_next, div_by_zero: 1'b0};
      end
    end
  end

  // Handshake must serialize divides
  assert property (@(posedge clk) disable iff (rst) accept |-> !busy)
    else $error("divide started while a division was still running");

endmodule

//--- source/calc_checker.sv
// Golden-model assertions on the external calculator handshake, instantiated inside the top
`timescale 1ns/1ps
`include "calc_config.svh"

module calc_checker
  import calc_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      req,
  input calc_req_t req_data,
  input logic      ack,
  input calc_rsp_t rsp
);

  logic      req_q;
  calc_req_t cap;

  // Reference result for one request
  // Divide by zero yields zero with the flag set
  function automatic calc_rsp_t ref_calc(input calc_req_t r);
    calc_rsp_t o;
    o = '0;
    case (r.op)
      OP_ADD: o.result = r.a + r.b;
      OP_SUB: o.result = r.a - r.b;
      OP_MUL: o.result = r.a * r.b;
      OP_DIV: begin
        if (r.b == '0) begin
          o.div_by_zero = 1'b1;
        end else begin
          o.result = r.a / r.b;
        end
      end
    endcase
    return o;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req;
    end
  end

  // Snapshot of the request at the rising edge of req
  always_ff @(posedge clk) begin
    if (req && !req_q) begin
      cap <= req_data;
    end
  end

  assert property (@(posedge clk) rst |=> !ack)
    else $error("ack high during or right after reset");

  assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
    else $error("ack rose without req high");

  assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
    else $error("ack fell before req fell");

  assert property (@(posedge clk) disable iff (rst) ack |-> rsp == ref_calc(cap))
    else $error("rsp mismatch op=%0d a=%0h b=%0h got=%0h exp=%0h",
                cap.op, cap.a, cap.b, rsp, ref_calc(cap));

  // Checked against the live request so a capture slip would show up here too
  assert property (@(posedge clk) disable iff (rst)
                   (ack && req) |-> rsp.div_by_zero == ((req_data.op == OP_DIV) &&
                                                        (req_data.b == '0)))
    else $error("div_by_zero flag wrong for op=%0d b=%0h", req_data.op, req_data.b);

  assert property (@(posedge clk) disable iff (rst) (ack && !$isunknown(cap)) |->
                   !$isunknown(rsp))
    else $error("rsp has X or Z with a known request");

endmodule

//--- source/calc_top.sv
// Calculator top level joining the req/ack handshake to the ALU, the divider and the checker
`timescale 1ns/1ps
`include "calc_config.svh"

module calc_top
  import calc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      req,
  input  calc_req_t req_data,
  output logic      ack,
  output calc_rsp_t rsp
);

  // Launch path shared by both units
  logic      start;
  calc_req_t op_req;
  // Per-unit return paths
  logic      alu_done;
  calc_rsp_t alu_rsp;
  logic      div_done;
  calc_rsp_t div_rsp;

  calc_handshake calc_handshake_inst (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp      (rsp),
    .start    (start),
    .op_req   (op_req),
    .alu_done (alu_done),
    .alu_rsp  (alu_rsp),
    .div_done (div_done),
    .div_rsp  (div_rsp)
  );

  calc_alu calc_alu_inst (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .op_req (op_req),
    .done   (alu_done),
    .rsp    (alu_rsp)
  );

  calc_divider #(
    .WIDTH (`CALC_WIDTH)
  ) calc_divider_inst (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .op_req (op_req),
    .done   (div_done),
    .rsp    (div_rsp)
  );

  // Observes only the external pins
  calc_checker calc_checker_inst (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp      (rsp)
  );

endmodule

//--- dv/calc_tb_tasks.svh
// Directed calculator tests, included into the testbench module body
task automatic test_reset();
  int i;
  // rst is already high from time zero and stays high for 5 edges
  for (i = 0; i < 5; i++) begin
    @(posedge clk);
    // First edge is the one that loads the reset values
    if (i > 0) begin
      check_value("test_reset ack", 64'd0, {63'd0, ack});
      check_value("test_reset rsp", 64'd0, {31'd0, rsp});
    end
  end
  rst <= 1'b0;
  repeat (3) begin
    @(posedge clk);
    check_value("test_reset ack idle", 64'd0, {63'd0, ack});
    check_value("test_reset rsp idle", 64'd0, {31'd0, rsp});
  end
endtask

task automatic test_add_sub();
  run_op("test_add_sub small add", 32'd1, 32'd2, OP_ADD, 0);
  run_op("test_add_sub add wrap", 32'hFFFF_FFFF, 32'd1, OP_ADD, 0);
  run_op("test_add_sub add top bits", 32'h8000_0000, 32'h8000_0000, OP_ADD, 0);
  run_op("test_add_sub add zeros", 32'd0, 32'd0, OP_ADD, 0);
  run_op("test_add_sub small sub", 32'd10, 32'd3, OP_SUB, 0);
  // Borrow out of zero wraps to all ones
  run_op("test_add_sub sub wrap", 32'd0, 32'd1, OP_SUB, 0);
  run_op("test_add_sub sub equal", 32'h1234_5678, 32'h1234_5678, OP_SUB, 0);
  run_op("test_add_sub sub zero", 32'hCAFE_F00D, 32'd0, OP_SUB, 0);
endtask

task automatic test_mul();
  run_op("test_mul small", 32'd1234, 32'd5678, OP_MUL, 0);
  // Full product is 2^32 so the low word is zero
  run_op("test_mul overflow", 32'h0001_0000, 32'h0001_0000, OP_MUL, 0);
  run_op("test_mul all ones", 32'hFFFF_FFFF, 32'hFFFF_FFFF, OP_MUL, 0);
  run_op("test_mul by zero", 32'h1234_5678, 32'd0, OP_MUL, 0);
  run_op("test_mul by one", 32'hDEAD_BEEF, 32'd1, OP_MUL, 0);
endtask

task automatic test_div();
  run_op("test_div exact", 32'd100, 32'd10, OP_DIV, 0);
  run_op("test_div inexact", 32'd100, 32'd7, OP_DIV, 0);
  run_op("test_div big divisor", 32'd5, 32'd9, OP_DIV, 0);
  run_op("test_div by one", 32'hDEAD_BEEF, 32'd1, OP_DIV, 0);
  run_op("test_div all ones", 32'hFFFF_FFFF, 32'hFFFF_FFFF, OP_DIV, 0);
  run_op("test_div top bit", 32'hFFFF_FFFF, 32'h0000_0003, OP_DIV, 0);
  // Short path with the flag raised
  run_op("test_div by zero", 32'd1234, 32'd0, OP_DIV, 0);
  run_op("test_div zero by zero", 32'd0, 32'd0, OP_DIV, 0);
  // Zero b on other opcodes keeps the flag clear
  run_op("test_div flag add", 32'd7, 32'd0, OP_ADD, 0);
  run_op("test_div flag sub", 32'd7, 32'd0, OP_SUB, 0);
  run_op("test_div flag mul", 32'd7, 32'd0, OP_MUL, 0);
endtask

task automatic test_handshake();
  int n;
  int hold;
  for (n = 0; n < 4; n++) begin
    hold = $urandom_range(12, 1);
    run_op("test_handshake held div", $urandom(), $urandom(), OP_DIV, hold);
    // Next request right after release
    run_op("test_handshake next add", $urandom(), $urandom(), OP_ADD, 0);
  end
  run_op("test_handshake held zero div", 32'd42, 32'd0, OP_DIV, 5);
endtask

task automatic test_random();
  int                     n;
  logic [`CALC_WIDTH-1:0] a;
  logic [`CALC_WIDTH-1:0] b;
  logic [1:0]             op_bits;
  for (n = 0; n < 200; n++) begin
    a       = $urandom();
    b       = $urandom();
    op_bits = 2'($urandom_range(3, 0));
    // Narrow divisors give large quotients now and then
    if ($urandom_range(3, 0) == 0) begin
      b = b >> $urandom_range(31, 0);
    end
    // Forced zero divisor
    if ($urandom_range(5, 0) == 0) begin
      b = '0;
    end
    run_op($sformatf("test_random #%0d", n), a, b, calc_op_e'(op_bits), 0);
  end
endtask

//--- dv/calc_tb.sv
// Testbench top for the calculator, driving calc_top over req/ack and checking every response
`timescale 1ns/1ps
`include "calc_config.svh"

module calc_tb
  import calc_pkg::*;
();

  // About 300 transactions of at most 40 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic      clk;
  logic      rst;
  logic      req;
  calc_req_t req_data;
  logic      ack;
  calc_rsp_t rsp;
  int        cycles = 0;

  calc_top calc_top_inst (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp      (rsp)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit in clock cycles
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles before all tests finished", cycles);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  // Expected response for one request
  // Multiply keeps the low word of the full product
  // Divide by zero gives zero with the flag set
  function automatic calc_rsp_t model_calc(input calc_req_t r);
    logic [2*`CALC_WIDTH-1:0] prod;
    calc_rsp_t                m;
    m.result      = '0;
    m.div_by_zero = 1'b0;
    prod = {{`CALC_WIDTH{1'b0}}, r.a} * {{`CALC_WIDTH{1'b0}}, r.b};
    case (r.op)
      OP_ADD: m.result = r.a + r.b;
      OP_SUB: m.result = r.a - r.b;
      OP_MUL: m.result = prod[`CALC_WIDTH-1:0];
      OP_DIV: begin
        if (r.b == '0) begin
          m.div_by_zero = 1'b1;
        end else begin
          m.result = r.a / r.b;
        end
      end
    endcase
    return m;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // One four-phase transaction
  // hold keeps req high for extra cycles after ack is seen
  task automatic do_txn(input string name, input calc_req_t r, input int hold,
                        output calc_rsp_t got);
    int i;
    @(posedge clk);
    req_data <= r;
    req      <= 1'b1;
    // Latency depends on the opcode, ack marks the end
    do begin
      @(posedge clk);
    end while (!ack);
    got = rsp;
    // Back-pressure window where ack and rsp must not move
    for (i = 0; i < hold; i++) begin
      @(posedge clk);
      check_value({name, " hold ack"}, 64'd1, {63'd0, ack});
      check_value({name, " hold rsp"}, {31'd0, got}, {31'd0, rsp});
    end
    req <= 1'b0;
    // ack is still high on the edge that first samples req low
    @(posedge clk);
    check_value({name, " ack after req drop"}, 64'd1, {63'd0, ack});
    do begin
      @(posedge clk);
    end while (ack);
  endtask

  // Build a request, send it and compare with the model
  task automatic run_op(input string name, input logic [`CALC_WIDTH-1:0] a,
                        input logic [`CALC_WIDTH-1:0] b, input calc_op_e op, input int hold);
    calc_req_t r;
    calc_rsp_t got;
    calc_rsp_t exp;
    r.a  = a;
    r.b  = b;
    r.op = op;
    exp  = model_calc(r);
    do_txn(name, r, hold, got);
    check_value(name, {31'd0, exp}, {31'd0, got});
  endtask

  `include "calc_tb_tasks.svh"

  initial begin
    void'($urandom(43664));
    rst      = 1'b1;
    req      = 1'b0;
    req_data = '0;
    test_reset();
    test_add_sub();
    test_mul();
    test_div();
    test_handshake();
    test_random();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+source
+incdir+dv
source/calc_pkg.sv
source/calc_handshake.sv
source/calc_alu.sv
source/calc_divider.sv
source/calc_checker.sv
source/calc_top.sv
dv/calc_tb.sv

//--- run.sh
#!/bin/sh
# Build the calculator testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f vlog.f --top-module calc_tb -o calc_sim \
  && ./obj_dir/calc_sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
